//--- files.f
hdl/busPkg.sv
hdl/periphPkg.sv
hdl/busArbiter.sv
hdl/dataSram.sv
hdl/dmaEngine.sv
hdl/watchdogTimer.sv
hdl/socTop.sv
verif/socTb.sv

//--- hdl/busArbiter.sv
module busArbiter (
	input logic clk,
	input logic rstN,
	input logic [busPkg::numMasters-1:0] mReqValid,
	input busPkg::busReq [busPkg::numMasters-1:0] mReq,
	output logic [busPkg::numMasters-1:0] mReqReady,
	output logic [busPkg::numMasters-1:0] mRespValid,
	output busPkg::busResp mResp,
	input logic [busPkg::numMasters-1:0] mRespReady,
	output logic sramSel,
	output logic dmaSel,
	output logic wdtSel,
	output busPkg::busReq slvReq,
	input logic sramReady,
	input logic dmaReady,
	input logic wdtReady,
	input logic sramRespValid,
	input logic dmaRespValid,
	input logic wdtRespValid,
	input busPkg::busResp sramResp,
	input busPkg::busResp dmaResp,
	input busPkg::busResp wdtResp,
	output logic slvRespReady
);
	typedef logic [$clog2(busPkg::numMasters)-1:0] masterIdxT;
	typedef enum logic [1:0] {tgtSram, tgtDma, tgtWdt, tgtErr} targetT;

	// Transfer in flight and who owns it
	logic busy;
	masterIdxT owner;
	targetT target;
	masterIdxT lastGrant;
	// Local error response for unmapped regions
	logic errPending;
	masterIdxT grantIdx;
	logic grantValid;
	targetT decoded;
	logic selReady;
	logic accept;
	logic respValidSel;
	logic respDone;

	// Round robin, the master not granted last wins a tie
	always_comb begin
		grantIdx = masterIdxT'(busPkg::masterHost);
		if (mReqValid[busPkg::masterHost] && mReqValid[busPkg::masterDma])
			grantIdx = ~lastGrant;
		else if (mReqValid[busPkg::masterDma])
			grantIdx = masterIdxT'(busPkg::masterDma);
	end

	assign grantValid = !busy && (|mReqValid);
	assign slvReq = mReq[grantIdx];

	// Region decode on the granted address
	always_comb begin
		case (slvReq.addr[busPkg::addrWidth-1 -: 4])
			busPkg::regionSram: decoded = tgtSram;
			busPkg::regionDma: decoded = tgtDma;
			busPkg::regionWdt: decoded = tgtWdt;
			default: decoded = tgtErr;
		endcase
		case (decoded)
			tgtSram: selReady = sramReady;
			tgtDma: selReady = dmaReady;
			tgtWdt: selReady = wdtReady;
			default: selReady = 1'b1;
		endcase
	end

	assign sramSel = grantValid && (decoded == tgtSram);
	assign dmaSel = grantValid && (decoded == tgtDma);
	assign wdtSel = grantValid && (decoded == tgtWdt);
	// No request register, acceptance is same cycle
	assign accept = grantValid && selReady;

	always_comb begin
		mReqReady = '0;
		if (accept)
			mReqReady[grantIdx] = 1'b1;
	end

	// Route the owning slave's response back
	always_comb begin
		case (target)
			tgtSram: begin
				respValidSel = sramRespValid;
				mResp = sramResp;
			end
			tgtDma: begin
				respValidSel = dmaRespValid;
				mResp = dmaResp;
			end
			tgtWdt: begin
				respValidSel = wdtRespValid;
				mResp = wdtResp;
			end
			default: begin
				respValidSel = errPending;
				mResp = '{rdata: '0, err: 1'b1};
			end
		endcase
		mRespValid = '0;
		if (busy)
			mRespValid[owner] = respValidSel;
	end

	// Only the owning slave has a response pending
	assign slvRespReady = busy && mRespReady[owner];
	assign respDone = busy && respValidSel && mRespReady[owner];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			busy <= 1'b0;
			owner <= masterIdxT'(busPkg::masterHost);
			target <= tgtSram;
			errPending <= 1'b0;
			// Host wins the first tie
			lastGrant <= masterIdxT'(busPkg::masterDma);
		end else if (accept) begin
			busy <= 1'b1;
			owner <= grantIdx;
			target <= decoded;
			lastGrant <= grantIdx;
			errPending <= (decoded == tgtErr);
		end else if (respDone) begin
			busy <= 1'b0;
			errPending <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) $onehot0({sramSel, dmaSel, wdtSel}));

	// Masters hold a waiting request
	for (genvar i = 0; i < busPkg::numMasters; i++) begin : gReqStable
		assert property (@(posedge clk) disable iff (!rstN)
			mReqValid[i] && !mReqReady[i] |=> mReqValid[i] && $stable(mReq[i]));
	end

endmodule

//--- hdl/busPkg.sv
package busPkg;

	// Bus widths
	localparam int addrWidth = 32;
	localparam int dataWidth = 32;
	localparam int strbWidth = 4;

	// Masters sharing the bus
	localparam int numMasters = 2;
	localparam int masterHost = 0;
	localparam int masterDma = 1;

	// Address map, upper nibble of the byte address
	localparam logic [3:0] regionSram = 4'd0;
	localparam logic [3:0] regionDma = 4'd1;
	localparam logic [3:0] regionWdt = 4'd2;

	// Data SRAM geometry in words
	localparam int sramDepth = 256;
	localparam int sramIndexWidth = 8;

	// Request channel, one beat per transfer
	typedef struct packed {
		logic write;
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
		logic [strbWidth-1:0] strb;
	} busReq;

	// Response channel
	// err marks a decode miss
	typedef struct packed {
		logic [dataWidth-1:0] rdata;
		logic err;
	} busResp;

endpackage

//--- hdl/dataSram.sv
module dataSram (
	input logic clk,
	input logic rstN,
	input logic sel,
	input busPkg::busReq req,
	output logic ready,
	output logic respValid,
	output busPkg::busResp resp,
	input logic respReady
);
	logic [busPkg::dataWidth-1:0] mem [busPkg::sramDepth];
	logic [busPkg::sramIndexWidth-1:0] index;
	logic [busPkg::dataWidth-1:0] rdataQ;
	logic accept;

	// Word index from addr[9:2]
	assign index = req.addr[busPkg::sramIndexWidth+1:2];
	// One response at a time
	assign ready = !respValid;
	assign accept = sel && ready;
	assign resp = '{rdata: rdataQ, err: 1'b0};

	// Response one cycle after acceptance, held under back-pressure
	always_ff @(posedge clk) begin
		if (!rstN)
			respValid <= 1'b0;
		else if (accept)
			respValid <= 1'b1;
		else if (respReady)
			respValid <= 1'b0;
	end

	// Byte-merged write
	// reads return the stored word, writes the old one
	always_ff @(posedge clk) begin
		if (accept) begin
			if (req.write) begin
				for (int b = 0; b < busPkg::strbWidth; b++) begin
					if (req.strb[b])
						mem[index][8*b +: 8] <= req.wdata[8*b +: 8];
				end
			end
			rdataQ <= mem[index];
		end
	end

	// Arbiter keeps the bus busy until the response is taken
	assert property (@(posedge clk) disable iff (!rstN) respValid |-> !sel);

endmodule

//--- hdl/dmaEngine.sv
module dmaEngine (
	input logic clk,
	input logic rstN,
	input logic regSel,
	input busPkg::busReq regReq,
	output logic regReady,
	output logic regRespValid,
	output busPkg::busResp regResp,
	input logic regRespReady,
	output logic mReqValid,
	output busPkg::busReq mReq,
	input logic mReqReady,
	input logic mRespValid,
	input busPkg::busResp mResp,
	output logic mRespReady,
	output logic dmaIrq
);
	typedef enum logic [2:0] {stIdle, stRdReq, stRdWait, stWrReq, stWrWait} stateT;

	stateT state;
	logic busy;
	logic doneQ;
	// Live copy pointers, advanced per word
	logic [busPkg::addrWidth-1:0] srcAddr;
	logic [busPkg::addrWidth-1:0] dstAddr;
	logic [periphPkg::dmaLenWidth-1:0] lenQ;
	// Word in transit between read and write
	logic [busPkg::dataWidth-1:0] dataQ;
	logic [busPkg::dataWidth-1:0] regRdata;
	logic regAccept;
	logic regWrite;
	logic [3:0] regOffset;

	assign busy = (state != stIdle);
	assign dmaIrq = doneQ;

	// Register slave port
	assign regReady = !regRespValid;
	assign regAccept = regSel && regReady;
	assign regWrite = regAccept && regReq.write;
	assign regOffset = regReq.addr[3:0];
	assign regResp = '{rdata: regRdata, err: 1'b0};

	// Master port, full-word transfers only
	assign mReqValid = (state == stRdReq) || (state == stWrReq);
	assign mRespReady = (state == stRdWait) || (state == stWrWait);
	assign mReq = '{
		write: (state == stWrReq),
		addr: (state == stWrReq) ? dstAddr : srcAddr,
		wdata: dataQ,
		strb: '1
	};

	always_ff @(posedge clk) begin
		if (!rstN)
			regRespValid <= 1'b0;
		else if (regAccept)
			regRespValid <= 1'b1;
		else if (regRespReady)
			regRespValid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (regAccept) begin
			case (regOffset)
				periphPkg::dmaRegSrc: regRdata <= srcAddr;
				periphPkg::dmaRegDst: regRdata <= dstAddr;
				periphPkg::dmaRegLen:
					regRdata <= {{(busPkg::dataWidth - periphPkg::dmaLenWidth){1'b0}}, lenQ};
				periphPkg::dmaRegCtrl:
					regRdata <= {{(busPkg::dataWidth - 2){1'b0}}, doneQ, busy};
				default: regRdata <= '0;
			endcase
		end
		// Capture read data for the following write
		if (state == stRdWait && mRespValid)
			dataQ <= mResp.rdata;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stIdle;
			doneQ <= 1'b0;
			srcAddr <= '0;
			dstAddr <= '0;
			lenQ <= '0;
		end else begin
			// Setup writes ignored mid-copy
			if (regWrite && !busy) begin
				case (regOffset)
					periphPkg::dmaRegSrc: srcAddr <= regReq.wdata;
					periphPkg::dmaRegDst: dstAddr <= regReq.wdata;
					periphPkg::dmaRegLen: lenQ <= regReq.wdata[periphPkg::dmaLenWidth-1:0];
					periphPkg::dmaRegCtrl: begin
						if (!regReq.wdata[0])
							doneQ <= 1'b0;
						else if (lenQ == '0)
							doneQ <= 1'b1;
						else begin
							doneQ <= 1'b0;
							state <= stRdReq;
						end
					end
					default: ;
				endcase
			end
			// Copy loop, one read then one write per word
			case (state)
				stRdReq: if (mReqReady) state <= stRdWait;
				stRdWait: if (mRespValid) state <= stWrReq;
				stWrReq: if (mReqReady) state <= stWrWait;
				stWrWait: begin
					if (mRespValid) begin
						srcAddr <= srcAddr + 32'd4;
						dstAddr <= dstAddr + 32'd4;
						lenQ <= lenQ - 1'b1;
						if (lenQ == 1) begin
							state <= stIdle;
							doneQ <= 1'b1;
						end else
							state <= stRdReq;
					end
				end
				default: ;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) mReqValid |-> busy);

endmodule

//--- hdl/periphPkg.sv
package periphPkg;

	// DMA register bank, offsets on addr[3:0]
	localparam logic [3:0] dmaRegSrc = 4'h0;
	localparam logic [3:0] dmaRegDst = 4'h4;
	localparam logic [3:0] dmaRegLen = 4'h8;
	// Bit 0 starts a copy, zero clears the interrupt
	localparam logic [3:0] dmaRegCtrl = 4'hC;

	// Word count width
	localparam int dmaLenWidth = 16;

	// Watchdog register bank
	localparam logic [3:0] wdtRegEnable = 4'h0;
	// Write sets reload and counter, read gives the counter
	localparam logic [3:0] wdtRegLoad = 4'h4;
	localparam logic [3:0] wdtRegKick = 4'h8;

	// Down-counter width
	localparam int wdtCountWidth = 32;

endpackage

//--- hdl/socTop.sv
module socTop (
	input logic clk,
	input logic rstN,
	input logic hostReqValid,
	input busPkg::busReq hostReq,
	output logic hostReqReady,
	output logic hostRespValid,
	output busPkg::busResp hostResp,
	input logic hostRespReady,
	output logic dmaIrq,
	output logic wdtTimeout
);
	// DMA master port
	logic dmaMReqValid;
	busPkg::busReq dmaMReq;
	logic dmaMReqReady;
	logic dmaMRespValid;
	logic dmaMRespReady;

	// Slave side of the arbiter
	logic sramSel;
	logic dmaSel;
	logic wdtSel;
	busPkg::busReq slvReq;
	logic sramReady;
	logic dmaReady;
	logic wdtReady;
	logic sramRespValid;
	logic dmaRespValid;
	logic wdtRespValid;
	busPkg::busResp sramResp;
	busPkg::busResp dmaResp;
	busPkg::busResp wdtResp;
	logic slvRespReady;

	// Host on index 0, DMA on index 1
	// Response bus is shared, the host port carries it
	busArbiter i_busArbiter (
		.clk(clk),
		.rstN(rstN),
		.mReqValid({dmaMReqValid, hostReqValid}),
		.mReq({dmaMReq, hostReq}),
		.mReqReady({dmaMReqReady, hostReqReady}),
		.mRespValid({dmaMRespValid, hostRespValid}),
		.mResp(hostResp),
		.mRespReady({dmaMRespReady, hostRespReady}),
		.sramSel(sramSel),
		.dmaSel(dmaSel),
		.wdtSel(wdtSel),
		.slvReq(slvReq),
		.sramReady(sramReady),
		.dmaReady(dmaReady),
		.wdtReady(wdtReady),
		.sramRespValid(sramRespValid),
		.dmaRespValid(dmaRespValid),
		.wdtRespValid(wdtRespValid),
		.sramResp(sramResp),
		.dmaResp(dmaResp),
		.wdtResp(wdtResp),
		.slvRespReady(slvRespReady)
	);

	dataSram i_dataSram (
		.clk(clk),
		.rstN(rstN),
		.sel(sramSel),
		.req(slvReq),
		.ready(sramReady),
		.respValid(sramRespValid),
		.resp(sramResp),
		.respReady(slvRespReady)
	);

	dmaEngine i_dmaEngine (
		.clk(clk),
		.rstN(rstN),
		.regSel(dmaSel),
		.regReq(slvReq),
		.regReady(dmaReady),
		.regRespValid(dmaRespValid),
		.regResp(dmaResp),
		.regRespReady(slvRespReady),
		.mReqValid(dmaMReqValid),
		.mReq(dmaMReq),
		.mReqReady(dmaMReqReady),
		.mRespValid(dmaMRespValid),
		.mResp(hostResp),
		.mRespReady(dmaMRespReady),
		.dmaIrq(dmaIrq)
	);

	watchdogTimer i_watchdogTimer (
		.clk(clk),
		.rstN(rstN),
		.sel(wdtSel),
		.req(slvReq),
		.ready(wdtReady),
		.respValid(wdtRespValid),
		.resp(wdtResp),
		.respReady(slvRespReady),
		.wdtTimeout(wdtTimeout)
	);

endmodule

//--- hdl/watchdogTimer.sv
module watchdogTimer (
	input logic clk,
	input logic rstN,
	input logic sel,
	input busPkg::busReq req,
	output logic ready,
	output logic respValid,
	output busPkg::busResp resp,
	input logic respReady,
	output logic wdtTimeout
);
	logic accept;
	logic regWrite;
	logic [3:0] offset;
	logic enableQ;
	logic [periphPkg::wdtCountWidth-1:0] reloadQ;
	logic [periphPkg::wdtCountWidth-1:0] countQ;
	logic [busPkg::dataWidth-1:0] rdataQ;

	assign ready = !respValid;
	assign accept = sel && ready;
	assign regWrite = accept && req.write;
	assign offset = req.addr[3:0];
	assign resp = '{rdata: rdataQ, err: 1'b0};

	always_ff @(posedge clk) begin
		if (!rstN)
			respValid <= 1'b0;
		else if (accept)
			respValid <= 1'b1;
		else if (respReady)
			respValid <= 1'b0;
	end

	// Load offset reads back the live counter
	always_ff @(posedge clk) begin
		if (accept) begin
			case (offset)
				periphPkg::wdtRegEnable: rdataQ <= {{(busPkg::dataWidth - 1){1'b0}}, enableQ};
				periphPkg::wdtRegLoad: rdataQ <= countQ;
				default: rdataQ <= '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			enableQ <= 1'b0;
			reloadQ <= '0;
			countQ <= '0;
			wdtTimeout <= 1'b0;
		end else begin
			// Count down, flag one cycle after hitting zero
			if (enableQ && countQ != '0)
				countQ <= countQ - 1'b1;
			if (enableQ && countQ == '0)
				wdtTimeout <= 1'b1;
			// Register writes take priority over counting
			if (regWrite) begin
				case (offset)
					periphPkg::wdtRegEnable: begin
						enableQ <= req.wdata[0];
						if (!req.wdata[0])
							wdtTimeout <= 1'b0;
					end
					periphPkg::wdtRegLoad: begin
						reloadQ <= req.wdata;
						countQ <= req.wdata;
						wdtTimeout <= 1'b0;
					end
					periphPkg::wdtRegKick: begin
						countQ <= reloadQ;
						wdtTimeout <= 1'b0;
					end
					default: ;
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) !enableQ |-> !wdtTimeout);

endmodule

//--- verif/socTb.sv
module socTb;
	timeunit 1ns;
	timeprecision 100ps;

	// Six behaviors, sized for the run limit
	localparam int numTests = 6;
	localparam logic [31:0] dmaBase = 32'h1000_0000;
	localparam logic [31:0] wdtBase = 32'h2000_0000;
	// Region 3 has no slave
	localparam logic [31:0] badBase = 32'h3000_0000;

	logic clk;
	logic rstN;
	logic hostReqValid;
	busPkg::busReq hostReq;
	logic hostReqReady;
	logic hostRespValid;
	busPkg::busResp hostResp;
	logic hostRespReady;
	logic dmaIrq;
	logic wdtTimeout;

	// Model of the data SRAM, word indexed
	logic [31:0] refMem [busPkg::sramDepth];
	// Pending comparisons
	string nameQ[$];
	logic [31:0] expQ[$];
	logic [31:0] actQ[$];
	int errors;
	int checks;
	integer seed;

	socTop i_socTop (
		.clk(clk),
		.rstN(rstN),
		.hostReqValid(hostReqValid),
		.hostReq(hostReq),
		.hostReqReady(hostReqReady),
		.hostRespValid(hostRespValid),
		.hostResp(hostResp),
		.hostRespReady(hostRespReady),
		.dmaIrq(dmaIrq),
		.wdtTimeout(wdtTimeout)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Byte strobe merge into a stored word
	function automatic logic [31:0] refMerge(input logic [31:0] old, input logic [31:0] wdata,
			input logic [3:0] strb);
		logic [31:0] merged;
		merged = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				merged[8*b +: 8] = wdata[8*b +: 8];
		end
		return merged;
	endfunction

	// Every byte tied to the word index
	function automatic logic [31:0] fillWord(input int idx);
		logic [7:0] a;
		a = idx[7:0];
		return {a ^ 8'hc3, ~a, a, a ^ 8'h5a};
	endfunction

	task automatic expectValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		nameQ.push_back(name);
		expQ.push_back(expected);
		actQ.push_back(actual);
	endtask

	// Comparator, drains the queues
	initial begin
		string name;
		logic [31:0] expected;
		logic [31:0] actual;
		forever begin
			wait (expQ.size() != 0);
			name = nameQ.pop_front();
			expected = expQ.pop_front();
			actual = actQ.pop_front();
			checks++;
			assert (actual === expected) else begin
				errors++;
				$display("ERR %s: expected %h, actual %h", name, expected, actual);
			end
		end
	end

	// One host transfer; stall holds respReady low that many cycles
	task automatic transfer(input busPkg::busReq req, input int stall,
			output busPkg::busResp resp);
		busPkg::busResp held;
		hostRespReady = (stall == 0);
		hostReq = req;
		hostReqValid = 1'b1;
		// Ready seen mid-cycle, transfer on the next edge
		forever begin
			@(negedge clk);
			if (hostReqReady)
				break;
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		hostReqValid = 1'b0;
		forever begin
			@(negedge clk);
			if (hostRespValid)
				break;
			@(posedge clk);
			#1;
		end
		if (stall > 0) begin
			held = hostResp;
			repeat (stall) begin
				@(negedge clk);
				assert (hostRespValid) else begin
					errors++;
					$display("Response valid dropped while the host held respReady low");
				end
				expectValue("stalled response hold", held.rdata, hostResp.rdata);
				expectValue("stalled response err hold", 32'(held.err), 32'(hostResp.err));
			end
			@(posedge clk);
			#1;
			hostRespReady = 1'b1;
			@(negedge clk);
		end
		resp = hostResp;
		// Accepting edge
		@(posedge clk);
		#1;
	endtask

	task automatic busWrite(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output busPkg::busResp resp);
		transfer('{write: 1'b1, addr: addr, wdata: data, strb: strb}, 0, resp);
	endtask

	task automatic busRead(input logic [31:0] addr, input int stall,
			output busPkg::busResp resp);
		transfer('{write: 1'b0, addr: addr, wdata: '0, strb: '0}, stall, resp);
	endtask

	task automatic sramWrite(input int idx, input logic [31:0] data, input logic [3:0] strb);
		busPkg::busResp resp;
		busWrite(32'(idx) << 2, data, strb, resp);
		refMem[idx] = refMerge(refMem[idx], data, strb);
	endtask

	task automatic sramCheck(input string name, input int idx, input int stall);
		busPkg::busResp resp;
		busRead(32'(idx) << 2, stall, resp);
		expectValue(name, refMem[idx], resp.rdata);
		expectValue({name, " err"}, 32'd0, 32'(resp.err));
	endtask

	// Program the DMA registers and start
	task automatic startCopy(input int src, input int dst, input int len);
		busPkg::busResp resp;
		busWrite(dmaBase | 32'h0, 32'(src) << 2, 4'hf, resp);
		busWrite(dmaBase | 32'h4, 32'(dst) << 2, 4'hf, resp);
		busWrite(dmaBase | 32'h8, 32'(len), 4'hf, resp);
		busWrite(dmaBase | 32'hc, 32'd1, 4'hf, resp);
	endtask

	// Wait for the interrupt, check the copy, clear
	task automatic finishCopy(input string name, input int src, input int dst, input int len);
		busPkg::busResp resp;
		int n;
		n = 0;
		while (!dmaIrq && n < 1000) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (dmaIrq) else begin
			errors++;
			$display("DMA interrupt did not rise within %0d cycles", n);
		end
		// Done set, busy clear
		busRead(dmaBase | 32'hc, 0, resp);
		expectValue({name, " ctrl done"}, 32'd2, resp.rdata);
		for (int i = 0; i < len; i++)
			refMem[dst + i] = refMem[src + i];
		for (int i = 0; i < len; i++)
			sramCheck(name, dst + i, 0);
		busWrite(dmaBase | 32'hc, 32'd0, 4'hf, resp);
		expectValue({name, " irq clear"}, 32'd0, 32'(dmaIrq));
	endtask

	// Run limit
	initial begin
		repeat (numTests * 2000 + 500) @(posedge clk);
		errors++;
		$display("Run timed out after %0d cycles", numTests * 2000 + 500);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		busPkg::busResp resp;
		logic [31:0] data;
		logic [3:0] strb;
		int idx;
		seed = 32'hd22;
		errors = 0;
		checks = 0;
		rstN = 1'b0;
		hostReqValid = 1'b0;
		hostReq = '0;
		hostRespReady = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rstN = 1'b1;

		// Quiet outputs, then strobed SRAM writes
		expectValue("reset outputs", 32'd0,
			32'({hostReqReady, hostRespValid, dmaIrq, wdtTimeout}));
		for (int i = 0; i < 128; i++)
			sramWrite(i, fillWord(i), 4'hf);
		for (int i = 0; i < 24; i++) begin
			idx = $unsigned($random(seed)) % 16;
			data = $random(seed);
			strb = $random(seed);
			sramWrite(idx, data, strb);
		end
		for (int i = 0; i < 16; i++)
			sramCheck("sram strobe readback", i, 0);

		// Unmapped region answers with an error
		busWrite(badBase | 32'h10, $random(seed), 4'hf, resp);
		expectValue("unmapped write err", 32'd1, 32'(resp.err));
		busRead(badBase | 32'h10, 0, resp);
		expectValue("unmapped read err", 32'd1, 32'(resp.err));
		expectValue("unmapped read rdata", 32'd0, resp.rdata);
		sramCheck("sram after unmapped write", 4, 0);

		// Plain DMA copy
		startCopy(32, 64, 8);
		finishCopy("dma copy", 32, 64, 8);

		// Host traffic on its own block while the DMA runs
		startCopy(40, 72, 8);
		busRead(dmaBase | 32'hc, 0, resp);
		expectValue("dma busy during copy", 32'd1, resp.rdata);
		for (int i = 96; i < 104; i++) begin
			data = $random(seed);
			strb = $random(seed);
			sramWrite(i, data, strb);
			sramCheck("host under dma", i, 0);
		end
		finishCopy("dma copy under load", 40, 72, 8);

		// Watchdog loaded with 20
		busWrite(wdtBase | 32'h4, 32'd20, 4'hf, resp);
		busWrite(wdtBase | 32'h0, 32'd1, 4'hf, resp);
		repeat (10) @(posedge clk);
		#1;
		expectValue("wdt low after 10", 32'd0, 32'(wdtTimeout));
		repeat (20) @(posedge clk);
		#1;
		expectValue("wdt high after 30", 32'd1, 32'(wdtTimeout));
		busWrite(wdtBase | 32'h8, 32'd0, 4'hf, resp);
		expectValue("wdt after kick", 32'd0, 32'(wdtTimeout));
		busWrite(wdtBase | 32'h0, 32'd0, 4'hf, resp);
		repeat (40) begin
			@(posedge clk);
			#1;
			expectValue("wdt while disabled", 32'd0, 32'(wdtTimeout));
		end

		// Back-pressure on a read
		sramCheck("stalled read", 5, 5);

		wait (expQ.size() == 0);
		repeat (2) @(posedge clk);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
